/* src/lsq_cfg.svh */
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// queue depths
////////////////////////////////////////////////////////////////////////////

// store entries, must stay a power of two for the wrap pointers
`define LSQ_SQ_DEPTH 8
// load entries
`define LSQ_LB_DEPTH 4

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

// word and address width
`define LSQ_XLEN 32
// destination register tag
`define LSQ_TAG_W 6

`endif

/* src/lsq_pkg.sv */
`include "lsq_cfg.svh"

package lsq_pkg;

    // sizes derived from the config header
    localparam int SQ_DEPTH = `LSQ_SQ_DEPTH;
    localparam int SQ_IDX_W = $clog2(SQ_DEPTH);
    localparam int LB_DEPTH = `LSQ_LB_DEPTH;
    localparam int LB_IDX_W = $clog2(LB_DEPTH);

    // store queue slot
    typedef logic [SQ_IDX_W-1:0] sq_idx_t;
    // slot plus wrap bit, head / tail / load age
    typedef logic [SQ_IDX_W:0] sq_ptr_t;
    // occupancy 0 .. depth
    typedef logic [SQ_IDX_W:0] sq_cnt_t;
    // load buffer slot
    typedef logic [LB_IDX_W-1:0] lb_idx_t;

    typedef logic [`LSQ_XLEN-1:0] word_t;
    typedef logic [`LSQ_TAG_W-1:0] tag_t;

    // one store entry
    typedef struct packed {
        logic  resolved;
        word_t addr;
        word_t data;
    } sq_entry_t;

    // one load entry
    // age is the store tail at allocation
    typedef struct packed {
        logic    resolved;
        sq_ptr_t age;
        word_t   addr;
        tag_t    tag;
    } lb_entry_t;

endpackage

/* src/sq_view_if.sv */
`timescale 1ns/1ps
`include "lsq_cfg.svh"

// registered store queue state as seen by the load side
interface sq_view_if;
    import lsq_pkg::*;

    // oldest live store, with wrap bit
    sq_ptr_t                   head;
    // per slot state
    logic [`LSQ_SQ_DEPTH-1:0]  resolved;
    word_t                     addr [`LSQ_SQ_DEPTH];
    word_t                     data [`LSQ_SQ_DEPTH];

    // store queue drives everything
    modport store (
        output head,
        output resolved,
        output addr,
        output data
    );

    // load buffer and the scans only look
    modport load (
        input head,
        input resolved,
        input addr,
        input data
    );

endinterface

/* src/sq_ptr_ctrl.sv */
`timescale 1ns/1ps

module sq_ptr_ctrl (
    input  logic              clock,
    input  logic              reset,
    input  logic              alloc,
    input  logic              retire,
    output lsq_pkg::sq_ptr_t  head,
    output lsq_pkg::sq_ptr_t  tail,
    output lsq_pkg::sq_cnt_t  count,
    output logic              full,
    output logic              empty
);
    import lsq_pkg::*;

    logic do_alloc;
    logic do_retire;

    // occupancy flags
    assign full  = (count == sq_cnt_t'(SQ_DEPTH));
    assign empty = (count == '0);

    // qualified strobes
    // alloc dropped when full, retire dropped when empty
    assign do_alloc  = alloc && !full;
    assign do_retire = retire && !empty;

    ////////////////////////////////////////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // wrap bit rolls over naturally
            if (do_alloc) begin
                tail <= tail + 1'b1;
            end
            if (do_retire) begin
                head <= head + 1'b1;
            end
            // both at once keeps count
            case ({do_alloc, do_retire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/store_queue.sv */
`timescale 1ns/1ps

module store_queue (
    input  logic              clock,
    input  logic              reset,
    input  logic              alloc,
    input  logic              resolve,
    input  lsq_pkg::sq_idx_t  resolve_idx,
    input  lsq_pkg::word_t    resolve_addr,
    input  lsq_pkg::word_t    resolve_data,
    input  logic              retire,
    output lsq_pkg::sq_idx_t  alloc_idx,
    output lsq_pkg::sq_ptr_t  tail,
    output logic              full,
    output logic              head_resolved,
    output logic              store_req_valid,
    output lsq_pkg::word_t    store_req_addr,
    output lsq_pkg::word_t    store_req_data,
    sq_view_if.store          view
);
    import lsq_pkg::*;

    sq_entry_t entries [SQ_DEPTH];

    sq_ptr_t head;
    sq_cnt_t count;
    logic    empty;
    sq_idx_t head_idx;
    sq_idx_t res_off;
    logic    res_live;
    logic    res_ok;

    // pointer / occupancy bookkeeping
    // retire reaches it only once the head is resolved
    sq_ptr_ctrl ptr_i (
        .clock  (clock),
        .reset  (reset),
        .alloc  (alloc),
        .retire (store_req_valid),
        .head   (head),
        .tail   (tail),
        .count  (count),
        .full   (full),
        .empty  (empty)
    );

    assign head_idx  = sq_idx_t'(head);
    assign alloc_idx = sq_idx_t'(tail);

    // slot is live when its distance from head is under count
    assign res_off  = resolve_idx - head_idx;
    assign res_live = sq_cnt_t'(res_off) < count;
    assign res_ok   = resolve && res_live && !entries[resolve_idx].resolved;

    ////////////////////////////////////////////////////////////////////////////
    // head retire and cache store request
    ////////////////////////////////////////////////////////////////////////////

    assign head_resolved   = !empty && entries[head_idx].resolved;
    assign store_req_valid = retire && head_resolved;
    assign store_req_addr  = entries[head_idx].addr;
    assign store_req_data  = entries[head_idx].data;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                entries[i].resolved <= 1'b0;
            end
        end else begin
            // fresh store, nothing known yet
            // tail sits on the head slot when full, so leave it then
            if (alloc && !full) begin
                entries[alloc_idx].resolved <= 1'b0;
            end
            if (res_ok) begin
                entries[resolve_idx].resolved <= 1'b1;
                entries[resolve_idx].addr     <= resolve_addr;
                entries[resolve_idx].data     <= resolve_data;
            end
            // drop the retired head
            if (store_req_valid) begin
                entries[head_idx].resolved <= 1'b0;
            end
        end
    end

    // registered state out to the load side
    assign view.head = head;

    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            view.resolved[i] = entries[i].resolved;
            view.addr[i]     = entries[i].addr;
            view.data[i]     = entries[i].data;
        end
    end

endmodule

/* src/older_store_scan.sv */
`timescale 1ns/1ps

module older_store_scan (
    input  lsq_pkg::sq_ptr_t  load_age,
    input  lsq_pkg::word_t    load_addr,
    sq_view_if.load           view,
    output logic              blocked,
    output logic              hit,
    output lsq_pkg::word_t    hit_data
);
    import lsq_pkg::*;

    // load distance from head, modulo twice the depth
    sq_ptr_t load_dist;
    logic    any_match;
    word_t   match_data;

    assign load_dist = load_age - view.head;

    ////////////////////////////////////////////////////////////////////////////
    // walk from head toward the load
    ////////////////////////////////////////////////////////////////////////////

    // slot k steps past head is older when k < load_dist
    // later matches overwrite, so the youngest one wins
    always_comb begin : scan
        sq_idx_t slot;

        blocked    = 1'b0;
        any_match  = 1'b0;
        match_data = '0;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            slot = sq_idx_t'(view.head) + sq_idx_t'(k);
            if (sq_ptr_t'(k) < load_dist) begin
                if (!view.resolved[slot]) begin
                    // address unknown, can't decide yet
                    blocked = 1'b1;
                end else if (view.addr[slot] == load_addr) begin
                    any_match  = 1'b1;
                    match_data = view.data[slot];
                end
            end
        end
    end

    // only meaningful when nothing older is pending
    assign hit      = any_match && !blocked;
    assign hit_data = match_data;

endmodule

/* src/load_buffer.sv */
`timescale 1ns/1ps

module load_buffer (
    input  logic              clock,
    input  logic              reset,
    input  logic              alloc,
    input  lsq_pkg::sq_ptr_t  sq_tail,
    input  logic              resolve,
    input  lsq_pkg::lb_idx_t  resolve_idx,
    input  lsq_pkg::word_t    resolve_addr,
    input  lsq_pkg::tag_t     resolve_tag,
    sq_view_if.load           view,
    output lsq_pkg::lb_idx_t  alloc_idx,
    output logic              full,
    output logic              fwd_valid,
    output lsq_pkg::word_t    fwd_data,
    output lsq_pkg::tag_t     fwd_tag,
    output logic              req_valid,
    output lsq_pkg::word_t    req_addr,
    output lsq_pkg::tag_t     req_tag
);
    import lsq_pkg::*;

    lb_entry_t entries [LB_DEPTH];

    // slot in use, inverse of the free list
    logic [LB_DEPTH-1:0] busy;

    logic [LB_DEPTH-1:0] blocked;
    logic [LB_DEPTH-1:0] hit;
    word_t               hit_data [LB_DEPTH];
    logic [LB_DEPTH-1:0] eligible;

    logic    issue_valid;
    lb_idx_t issue_idx;
    logic    res_ok;

    ////////////////////////////////////////////////////////////////////////////
    // free list
    ////////////////////////////////////////////////////////////////////////////

    assign full = &busy;

    // lowest free slot
    always_comb begin
        alloc_idx = '0;
        for (int i = LB_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_idx = lb_idx_t'(i);
            end
        end
    end

    // late resolve only for a live, unresolved slot
    assign res_ok = resolve && busy[resolve_idx] && !entries[resolve_idx].resolved;

    ////////////////////////////////////////////////////////////////////////////
    // per entry older-store check and issue pick
    ////////////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < LB_DEPTH; g++) begin : g_scan
        older_store_scan scan_i (
            .load_age  (entries[g].age),
            .load_addr (entries[g].addr),
            .view      (view),
            .blocked   (blocked[g]),
            .hit       (hit[g]),
            .hit_data  (hit_data[g])
        );

        assign eligible[g] = busy[g] && entries[g].resolved && !blocked[g];
    end

    // lowest index first, one per cycle
    always_comb begin
        issue_idx = '0;
        for (int i = LB_DEPTH - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                issue_idx = lb_idx_t'(i);
            end
        end
    end

    assign issue_valid = |eligible;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= '0;
            fwd_valid <= 1'b0;
            req_valid <= 1'b0;
            for (int i = 0; i < LB_DEPTH; i++) begin
                entries[i].resolved <= 1'b0;
            end
        end else begin
            // new load is ordered after every store allocated so far
            if (alloc && !full) begin
                busy[alloc_idx]             <= 1'b1;
                entries[alloc_idx].resolved <= 1'b0;
                entries[alloc_idx].age      <= sq_tail;
            end
            if (res_ok) begin
                entries[resolve_idx].resolved <= 1'b1;
                entries[resolve_idx].addr     <= resolve_addr;
                entries[resolve_idx].tag      <= resolve_tag;
            end
            // issued slot goes back on the free list now
            if (issue_valid) begin
                busy[issue_idx]             <= 1'b0;
                entries[issue_idx].resolved <= 1'b0;
            end
            // forward on hit, else read the cache
            fwd_valid <= issue_valid && hit[issue_idx];
            req_valid <= issue_valid && !hit[issue_idx];
            if (issue_valid) begin
                fwd_data <= hit_data[issue_idx];
                fwd_tag  <= entries[issue_idx].tag;
                req_addr <= entries[issue_idx].addr;
                req_tag  <= entries[issue_idx].tag;
            end
        end
    end

endmodule

/* src/lsq_top.sv */
`timescale 1ns/1ps

module lsq_top (
    input  logic              clock,
    input  logic              reset,
    // store allocation
    input  logic              sq_alloc,
    output lsq_pkg::sq_idx_t  sq_alloc_idx,
    output logic              sq_full,
    // store resolution
    input  logic              sq_resolve,
    input  lsq_pkg::sq_idx_t  sq_resolve_idx,
    input  lsq_pkg::word_t    sq_resolve_addr,
    input  lsq_pkg::word_t    sq_resolve_data,
    // store retirement
    input  logic              sq_retire,
    output logic              sq_head_resolved,
    // load allocation
    input  logic              lb_alloc,
    output lsq_pkg::lb_idx_t  lb_alloc_idx,
    output logic              lb_full,
    // load resolution
    input  logic              lb_resolve,
    input  lsq_pkg::lb_idx_t  lb_resolve_idx,
    input  lsq_pkg::word_t    lb_resolve_addr,
    input  lsq_pkg::tag_t     lb_resolve_tag,
    // cache store request
    output logic              store_req_valid,
    output lsq_pkg::word_t    store_req_addr,
    output lsq_pkg::word_t    store_req_data,
    // forwarded load result
    output logic              load_fwd_valid,
    output lsq_pkg::word_t    load_fwd_data,
    output lsq_pkg::tag_t     load_fwd_tag,
    // cache load request
    output logic              load_req_valid,
    output lsq_pkg::word_t    load_req_addr,
    output lsq_pkg::tag_t     load_req_tag
);
    import lsq_pkg::*;

    // store tail feeds the load age
    sq_ptr_t sq_tail;

    sq_view_if view_i ();

    store_queue sq_i (
        .clock           (clock),
        .reset           (reset),
        .alloc           (sq_alloc),
        .resolve         (sq_resolve),
        .resolve_idx     (sq_resolve_idx),
        .resolve_addr    (sq_resolve_addr),
        .resolve_data    (sq_resolve_data),
        .retire          (sq_retire),
        .alloc_idx       (sq_alloc_idx),
        .tail            (sq_tail),
        .full            (sq_full),
        .head_resolved   (sq_head_resolved),
        .store_req_valid (store_req_valid),
        .store_req_addr  (store_req_addr),
        .store_req_data  (store_req_data),
        .view            (view_i.store)
    );

    load_buffer lb_i (
        .clock        (clock),
        .reset        (reset),
        .alloc        (lb_alloc),
        .sq_tail      (sq_tail),
        .resolve      (lb_resolve),
        .resolve_idx  (lb_resolve_idx),
        .resolve_addr (lb_resolve_addr),
        .resolve_tag  (lb_resolve_tag),
        .view         (view_i.load),
        .alloc_idx    (lb_alloc_idx),
        .full         (lb_full),
        .fwd_valid    (load_fwd_valid),
        .fwd_data     (load_fwd_data),
        .fwd_tag      (load_fwd_tag),
        .req_valid    (load_req_valid),
        .req_addr     (load_req_addr),
        .req_tag      (load_req_tag)
    );

endmodule

/* verif/lsq_tb.sv */
`timescale 1ns/1ps
`include "lsq_cfg.svh"

module lsq_tb;
    import lsq_pkg::*;

    // directed part is ~150 cycles, random part plus drain under 600
    localparam int RANDOM_CYCLES = 400;
    localparam int MAX_CYCLES    = 4000;

    logic     clock = 1'b0;
    logic     reset;
    logic     sq_alloc, sq_full, sq_resolve, sq_retire, sq_head_resolved;
    sq_idx_t  sq_alloc_idx, sq_resolve_idx;
    word_t    sq_resolve_addr, sq_resolve_data;
    logic     lb_alloc, lb_full, lb_resolve;
    lb_idx_t  lb_alloc_idx, lb_resolve_idx;
    word_t    lb_resolve_addr;
    tag_t     lb_resolve_tag;
    logic     store_req_valid, load_fwd_valid, load_req_valid;
    word_t    store_req_addr, store_req_data, load_fwd_data, load_req_addr;
    tag_t     load_fwd_tag, load_req_tag;

    // store side model
    logic     st_res  [`LSQ_SQ_DEPTH];
    word_t    st_addr [`LSQ_SQ_DEPTH];
    word_t    st_data [`LSQ_SQ_DEPTH];
    sq_ptr_t  st_head;
    sq_ptr_t  st_tail;
    int       st_count;
    // load side model, indexed by buffer slot
    logic     ld_busy     [`LSQ_LB_DEPTH];
    logic     ld_resolved [`LSQ_LB_DEPTH];
    sq_ptr_t  ld_age      [`LSQ_LB_DEPTH];
    word_t    ld_addr     [`LSQ_LB_DEPTH];
    tag_t     ld_tag      [`LSQ_LB_DEPTH];

    string    test_name = "reset";
    int       cycles = 0;
    int       next_tag = 0;

    lsq_top dut_i (.*);

    always #4 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic compare_value(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("error in %s, %s: expected %0h, actual %0h",
                                        test_name, what, expected, actual));
        end
    endtask

    // age rule: older when distance from head is below the load's distance
    // result bits {blocked, forward, data}, youngest older match wins
    function automatic logic [`LSQ_XLEN+1:0] reference_load(input sq_ptr_t age,
                                                             input word_t addr);
        int      load_dist;
        sq_idx_t slot;
        logic    blocked;
        logic    fwd;
        word_t   data;

        load_dist = int'(sq_ptr_t'(age - st_head));
        blocked   = 1'b0;
        fwd       = 1'b0;
        data      = '0;
        for (int k = 0; k < st_count; k++) begin
            slot = sq_idx_t'(st_head + sq_ptr_t'(k));
            if (k < load_dist) begin
                if (!st_res[slot]) begin
                    blocked = 1'b1;
                end else if (st_addr[slot] == addr) begin
                    fwd  = 1'b1;
                    data = st_data[slot];
                end
            end
        end
        return {blocked, fwd, data};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // model update and compare, sampled at the rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin : model_check
        sq_idx_t head_idx;
        logic    head_res;
        logic    exp_store_req;
        int      lslot;
        int      free_idx;
        tag_t    out_tag;
        logic [`LSQ_XLEN+1:0] ref_res;

        if (reset) begin
            st_head  = '0;
            st_tail  = '0;
            st_count = 0;
            for (int i = 0; i < `LSQ_SQ_DEPTH; i++) st_res[i] = 1'b0;
            for (int i = 0; i < `LSQ_LB_DEPTH; i++) begin
                ld_busy[i]     = 1'b0;
                ld_resolved[i] = 1'b0;
            end
        end else begin
            head_idx = sq_idx_t'(st_head);
            head_res = (st_count > 0) && st_res[head_idx];
            compare_value("sq_alloc_idx", sq_idx_t'(st_tail), sq_alloc_idx);
            compare_value("sq_full", st_count == `LSQ_SQ_DEPTH, sq_full);
            compare_value("sq_head_resolved", head_res, sq_head_resolved);
            // store request only for a resolved head
            exp_store_req = sq_retire && head_res;
            compare_value("store_req_valid", exp_store_req, store_req_valid);
            if (exp_store_req) begin
                compare_value("store_req_addr", st_addr[head_idx], store_req_addr);
                compare_value("store_req_data", st_data[head_idx], store_req_data);
            end

            // load result registered at the previous edge
            if (load_fwd_valid && load_req_valid) begin
                stop_with_failure("forward and cache read were raised in the same cycle");
            end
            if (load_fwd_valid || load_req_valid) begin
                out_tag = load_fwd_valid ? load_fwd_tag : load_req_tag;
                lslot   = -1;
                for (int i = 0; i < `LSQ_LB_DEPTH; i++) begin
                    if (ld_busy[i] && ld_resolved[i] && ld_tag[i] == out_tag) lslot = i;
                end
                if (lslot < 0) begin
                    stop_with_failure($sformatf("load result with tag %0d matches no waiting load",
                                                out_tag));
                end
                ref_res = reference_load(ld_age[lslot], ld_addr[lslot]);
                if (ref_res[`LSQ_XLEN+1]) begin
                    stop_with_failure("a load issued while an older store was unresolved");
                end
                compare_value("load forwarded", ref_res[`LSQ_XLEN], load_fwd_valid);
                if (ref_res[`LSQ_XLEN]) begin
                    compare_value("load_fwd_data", ref_res[`LSQ_XLEN-1:0], load_fwd_data);
                end else begin
                    compare_value("load_req_addr", ld_addr[lslot], load_req_addr);
                end
                ld_busy[lslot]     = 1'b0;
                ld_resolved[lslot] = 1'b0;
            end

            // lowest free load slot
            free_idx = -1;
            for (int i = `LSQ_LB_DEPTH - 1; i >= 0; i--) begin
                if (!ld_busy[i]) free_idx = i;
            end
            compare_value("lb_full", free_idx < 0, lb_full);
            if (free_idx >= 0) compare_value("lb_alloc_idx", free_idx, lb_alloc_idx);

            if (lb_resolve && ld_busy[lb_resolve_idx] && !ld_resolved[lb_resolve_idx]) begin
                ld_resolved[lb_resolve_idx] = 1'b1;
                ld_addr[lb_resolve_idx]     = lb_resolve_addr;
                ld_tag[lb_resolve_idx]      = lb_resolve_tag;
            end
            // age is the tail before this edge
            if (lb_alloc && free_idx >= 0) begin
                ld_busy[free_idx]     = 1'b1;
                ld_resolved[free_idx] = 1'b0;
                ld_age[free_idx]      = st_tail;
            end

            // resolve only a live, still open store
            if (sq_resolve && !st_res[sq_resolve_idx] &&
                ((int'(sq_resolve_idx) - int'(head_idx) + `LSQ_SQ_DEPTH)
                 % `LSQ_SQ_DEPTH) < st_count) begin
                st_res[sq_resolve_idx]  = 1'b1;
                st_addr[sq_resolve_idx] = sq_resolve_addr;
                st_data[sq_resolve_idx] = sq_resolve_data;
            end
            if (sq_alloc && st_count < `LSQ_SQ_DEPTH) begin
                st_res[sq_idx_t'(st_tail)] = 1'b0;
                st_tail  = st_tail + 1'b1;
                st_count = st_count + 1;
            end
            if (exp_store_req) begin
                st_res[head_idx] = 1'b0;
                st_head  = st_head + 1'b1;
                st_count = st_count - 1;
            end
        end
    end

    // run limit
    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            stop_with_failure($sformatf("timeout, run passed %0d cycles", MAX_CYCLES));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic clear_strobes();
        sq_alloc        = 1'b0;
        sq_resolve      = 1'b0;
        sq_resolve_idx  = '0;
        sq_resolve_addr = '0;
        sq_resolve_data = '0;
        sq_retire       = 1'b0;
        lb_alloc        = 1'b0;
        lb_resolve      = 1'b0;
        lb_resolve_idx  = '0;
        lb_resolve_addr = '0;
        lb_resolve_tag  = '0;
    endtask

    // strobes last one cycle
    task automatic next_cycle();
        @(negedge clock);
        clear_strobes();
    endtask

    task automatic drive_store_resolve(input int slot, input word_t addr, input word_t data);
        sq_resolve      = 1'b1;
        sq_resolve_idx  = sq_idx_t'(slot);
        sq_resolve_addr = addr;
        sq_resolve_data = data;
    endtask

    task automatic drive_load_resolve(input int slot, input word_t addr);
        lb_resolve      = 1'b1;
        lb_resolve_idx  = lb_idx_t'(slot);
        lb_resolve_addr = addr;
        lb_resolve_tag  = tag_t'(next_tag);
        next_tag++;
    endtask

    // small address set so loads hit stores often
    function automatic word_t pick_addr();
        return 32'h4000 + 4 * ($urandom % 4);
    endfunction

    function automatic int find_open_store(input int start);
        int idx;

        for (int k = 0; k < st_count; k++) begin
            idx = (int'(sq_idx_t'(st_head)) + (start + k) % st_count) % `LSQ_SQ_DEPTH;
            if (!st_res[idx]) return idx;
        end
        return -1;
    endfunction

    function automatic int find_open_load(input int start);
        int idx;

        for (int k = 0; k < `LSQ_LB_DEPTH; k++) begin
            idx = (start + k) % `LSQ_LB_DEPTH;
            if (ld_busy[idx] && !ld_resolved[idx]) return idx;
        end
        return -1;
    endfunction

    function automatic logic loads_pending();
        for (int i = 0; i < `LSQ_LB_DEPTH; i++) begin
            if (ld_busy[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic wait_load_result(input int limit);
        int waited;

        waited = 0;
        while (!(load_fwd_valid || load_req_valid)) begin
            if (waited >= limit) begin
                stop_with_failure($sformatf("no load result within %0d cycles", limit));
            end
            next_cycle();
            waited++;
        end
    endtask

    // retire only while no load waits, so forward sources stay put
    task automatic random_cycle();
        int slot;

        sq_alloc = ($urandom % 3) == 0;
        lb_alloc = ($urandom % 4) == 0;
        if (st_count > 0 && $urandom % 2 == 1) begin
            slot = find_open_store($urandom % st_count);
            if (slot >= 0) drive_store_resolve(slot, pick_addr(), $urandom);
        end
        if ($urandom % 2 == 1) begin
            slot = find_open_load($urandom % `LSQ_LB_DEPTH);
            if (slot >= 0) drive_load_resolve(slot, pick_addr());
        end
        sq_retire = !loads_pending() && ($urandom % 2 == 1);
    endtask

    // resolve what is open, let loads finish, then empty the store queue
    task automatic drain();
        int slot;

        while (find_open_store(0) >= 0 || loads_pending()) begin
            slot = find_open_store(0);
            if (slot >= 0) drive_store_resolve(slot, pick_addr(), $urandom);
            slot = find_open_load(0);
            if (slot >= 0) drive_load_resolve(slot, pick_addr());
            next_cycle();
        end
        while (st_count > 0) begin
            sq_retire = 1'b1;
            next_cycle();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int unsigned seed;
        int          order [8];
        int          a_idx, b_idx, c_idx, ld_slot;
        tag_t        tag;

        seed = 32'h44d8_6588;
        void'($urandom(seed));
        reset = 1'b1;
        clear_strobes();
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_name = "after reset";
        compare_value("load valids", 0, load_fwd_valid | load_req_valid);
        compare_value("sq_full", 0, sq_full);
        compare_value("lb_full", 0, lb_full);
        // two extra allocations each, both must be dropped
        repeat (`LSQ_SQ_DEPTH + 2) begin
            sq_alloc = 1'b1;
            next_cycle();
        end
        compare_value("sq_full", 1, sq_full);
        repeat (`LSQ_LB_DEPTH + 2) begin
            lb_alloc = 1'b1;
            next_cycle();
        end
        compare_value("lb_full", 1, lb_full);

        test_name = "in-order retirement";
        sq_retire = 1'b1;
        next_cycle();
        order = '{5, 2, 7, 0, 3, 6, 1, 4};
        foreach (order[i]) begin
            drive_store_resolve(order[i], 32'h1000 + 4 * order[i], $urandom);
            next_cycle();
        end
        repeat (`LSQ_SQ_DEPTH) begin
            sq_retire = 1'b1;
            next_cycle();
        end

        // store queue now empty, so each load goes straight to the cache
        test_name = "load with no older store";
        for (int s = 0; s < `LSQ_LB_DEPTH; s++) begin
            drive_load_resolve(s, 32'h2000 + 4 * s);
            tag = lb_resolve_tag;
            next_cycle();
            compare_value("load_req_valid one edge after", 0, load_req_valid);
            next_cycle();
            compare_value("load_req_valid two edges after", 1, load_req_valid);
            compare_value("load_req_addr", 32'h2000 + 4 * s, load_req_addr);
            compare_value("load_req_tag", tag, load_req_tag);
        end
        next_cycle();

        test_name = "blocked load";
        a_idx = sq_alloc_idx;
        sq_alloc = 1'b1;
        next_cycle();
        b_idx = sq_alloc_idx;
        sq_alloc = 1'b1;
        next_cycle();
        drive_store_resolve(a_idx, 32'h3000, 32'haaaa_0001);
        next_cycle();
        ld_slot = lb_alloc_idx;
        lb_alloc = 1'b1;
        next_cycle();
        // younger store at the same address, must not forward
        c_idx = sq_alloc_idx;
        sq_alloc = 1'b1;
        next_cycle();
        drive_store_resolve(c_idx, 32'h3000, 32'hcccc_0003);
        next_cycle();
        drive_load_resolve(ld_slot, 32'h3000);
        next_cycle();
        repeat (6) begin
            compare_value("load held", 0, load_fwd_valid | load_req_valid);
            next_cycle();
        end
        drive_store_resolve(b_idx, 32'h3000, 32'hbbbb_0002);
        next_cycle();
        wait_load_result(20);
        compare_value("load_fwd_valid", 1, load_fwd_valid);
        compare_value("load_fwd_data", 32'hbbbb_0002, load_fwd_data);
        next_cycle();
        repeat (3) begin
            sq_retire = 1'b1;
            next_cycle();
        end

        test_name = "random mix";
        repeat (RANDOM_CYCLES) begin
            random_cycle();
            next_cycle();
        end
        drain();
        next_cycle();

        $display(">>> PASS");
        $finish;
    end

endmodule

/* compile.f */
+incdir+src
src/lsq_pkg.sv
src/sq_view_if.sv
src/sq_ptr_ctrl.sv
src/store_queue.sv
src/older_store_scan.sv
src/load_buffer.sv
src/lsq_top.sv
verif/lsq_tb.sv

/* Bender.yml */
package:
  name: lsq

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/lsq_pkg.sv
      - src/sq_view_if.sv
      - src/sq_ptr_ctrl.sv
      - src/store_queue.sv
      - src/older_store_scan.sv
      - src/load_buffer.sv
      - src/lsq_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/lsq_tb.sv
